// ==== design/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'd0,
        OPC_REGIMM  = 6'd1,
        OPC_J       = 6'd2,
        OPC_JAL     = 6'd3,
        OPC_BEQ     = 6'd4,
        OPC_BNE     = 6'd5,
        OPC_BLEZ    = 6'd6,
        OPC_BGTZ    = 6'd7,
        OPC_ADDI    = 6'd8,
        OPC_ADDIU   = 6'd9,
        OPC_SLTI    = 6'd10,
        OPC_SLTIU   = 6'd11,
        OPC_ANDI    = 6'd12,
        OPC_ORI     = 6'd13,
        OPC_XORI    = 6'd14,
        OPC_LUI     = 6'd15,
        OPC_COP0    = 6'd16,
        // loads
        OPC_LB      = 6'd32,
        OPC_LH      = 6'd33,
        OPC_LWL     = 6'd34,
        OPC_LW      = 6'd35,
        OPC_LBU     = 6'd36,
        OPC_LHU     = 6'd37,
        // stores
        OPC_SB      = 6'd40,
        OPC_SH      = 6'd41,
        OPC_SW      = 6'd43
    } opcode_e;

    // decoded instruction class
    typedef enum logic [2:0] {
        OP_ALU_R    = 3'd0,
        OP_ALU_I    = 3'd1,
        OP_LOAD     = 3'd2,
        OP_STORE    = 3'd3,
        OP_BRANCH   = 3'd4,
        OP_JUMP     = 3'd5,
        OP_ERET     = 3'd6,
        OP_RESERVED = 3'd7
    } op_class_e;

    // funct and rs codes needed by the classifier
    localparam logic [5:0] FUNCT_JR   = 6'd8;
    localparam logic [5:0] FUNCT_ERET = 6'd24;
    // cop0 "co" form, rs field = 1_0000
    localparam logic [4:0] RS_CO      = 5'd16;

    // host register map, memory window sits below these
    localparam logic [31:0] CTRL_ADDR     = 32'h0000_0400;
    localparam logic [31:0] START_PC_ADDR = 32'h0000_0404;
    localparam int          CTRL_RUN_BIT  = 0;

    // queue entry = {pc, instr, addr_err}
    localparam int QUEUE_W         = 65;
    localparam int ENTRY_PC_LSB    = 33;
    localparam int ENTRY_INSTR_LSB = 1;
    localparam int ENTRY_ERR_BIT   = 0;

endpackage

`default_nettype wire

// ==== design/imem_apb.sv ====
`default_nettype none

module imem_apb #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [31:0] fetch_addr,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [31:0] fetch_instr,
    output logic        run,
    output logic [31:0] start_pc
);
    import frontend_pkg::*;

    localparam int          AW        = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;
    localparam logic [31:0] MEM_BYTES = 32'(IMEM_DEPTH * 4);

    logic [31:0]   mem [IMEM_DEPTH];
    logic          ctrl_hit;
    logic          pc_hit;
    logic          mem_hit;
    logic          access;
    logic [AW-1:0] apb_idx;
    logic [29:0]   fetch_word;

    // address decode, registers take priority over the window
    assign ctrl_hit = (paddr == CTRL_ADDR);
    assign pc_hit   = (paddr == START_PC_ADDR);
    assign mem_hit  = !ctrl_hit && !pc_hit && (paddr < MEM_BYTES);
    assign apb_idx  = paddr[AW+1:2];

    // access phase of any transfer
    assign access = psel && penable;

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !(ctrl_hit || pc_hit || mem_hit);

    // host writes land at the access edge
    always_ff @(posedge clk) begin
        if (access && pwrite && mem_hit) begin
            mem[apb_idx] <= pwdata;
        end
    end

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            run      <= 1'b0;
            start_pc <= '0;
        end else if (access && pwrite) begin
            if (ctrl_hit) begin
                run <= pwdata[CTRL_RUN_BIT];
            end
            if (pc_hit) begin
                start_pc <= pwdata;
            end
        end
    end

    // read mux for the host
    always_comb begin
        prdata = '0;
        if (ctrl_hit) begin
            prdata[CTRL_RUN_BIT] = run;
        end else if (pc_hit) begin
            prdata = start_pc;
        end else if (mem_hit) begin
            prdata = mem[apb_idx];
        end
    end

    // fetch side, word index wraps on depth
    assign fetch_word  = fetch_addr[31:2] % 30'(IMEM_DEPTH);
    assign fetch_instr = mem[fetch_word[AW-1:0]];

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             run,
    input  logic [31:0]                      start_pc,
    input  logic [31:0]                      fetch_instr,
    input  logic                             full,
    output logic [31:0]                      fetch_addr,
    output logic                             push,
    output logic [frontend_pkg::QUEUE_W-1:0] push_data
);

    localparam int            AW       = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;
    localparam logic [AW-1:0] IDX_LAST = AW'(IMEM_DEPTH - 1);

    logic          run_q;
    logic          run_rise;
    logic [31:0]   pc;
    logic [31:0]   pc_next;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] word_next;
    logic          addr_err;

    // run edge, pc gets loaded here
    assign run_rise = run && !run_q;

    // one word per cycle once pc is loaded
    assign push = run && run_q && !full;

    // misaligned start, step by 4 keeps the low bits
    assign addr_err = (pc[1:0] != 2'b00);

    // word index wraps at depth
    // upper and byte bits pass through
    assign word_idx  = pc[AW+1:2];
    assign word_next = (word_idx == IDX_LAST) ? '0 : word_idx + 1'b1;

    always_comb begin
        pc_next         = pc;
        pc_next[AW+1:2] = word_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            pc    <= '0;
        end else begin
            run_q <= run;
            if (run_rise) begin
                pc <= start_pc;
            end else if (push) begin
                pc <= pc_next;
            end
        end
    end

    assign fetch_addr = pc;

    // entry layout {pc, instr, addr_err}
    assign push_data = {pc, fetch_instr, addr_err};

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             push,
    input  logic [frontend_pkg::QUEUE_W-1:0] push_data,
    input  logic                             pop,
    output logic [frontend_pkg::QUEUE_W-1:0] head_data,
    output logic                             full,
    output logic                             empty
);
    import frontend_pkg::*;

    localparam int            PW       = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int            CW       = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PW-1:0] PTR_LAST = PW'(QUEUE_DEPTH - 1);
    localparam logic [CW-1:0] CNT_FULL = CW'(QUEUE_DEPTH);

    logic [QUEUE_W-1:0] slots [QUEUE_DEPTH];
    logic [PW-1:0]      wptr;
    logic [PW-1:0]      rptr;
    logic [CW-1:0]      count;
    logic               do_push;
    logic               do_pop;

    assign full  = (count == CNT_FULL);
    assign empty = (count == '0);

    // push into a full queue only with a pop in the same cycle
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    // payload store
    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wptr] <= push_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == PTR_LAST) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == PTR_LAST) ? '0 : rptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is always the oldest entry
    assign head_data = slots[rptr];

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
`default_nettype none

module decode_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             empty,
    input  logic [frontend_pkg::QUEUE_W-1:0] head_data,
    input  logic                             out_ready,
    output logic                             pop,
    output logic                             out_valid,
    output logic [31:0]                      out_pc,
    output frontend_pkg::op_class_e          out_op_class,
    output logic [4:0]                       out_rs,
    output logic [4:0]                       out_rt,
    output logic [4:0]                       out_rd,
    output logic [4:0]                       out_sa,
    output logic [5:0]                       out_funct,
    output logic [31:0]                      out_imm_ext,
    output logic [31:0]                      out_branch_target,
    output logic [31:0]                      out_jump_target,
    output logic                             out_in_delay_slot,
    output logic                             out_addr_err
);
    import frontend_pkg::*;

    logic [31:0] head_pc;
    logic [31:0] head_instr;
    logic        head_err;
    opcode_e     op;
    logic [4:0]  rs;
    logic [5:0]  funct;
    logic [15:0] imm;
    op_class_e   op_class;
    logic        zero_ext;
    logic [31:0] imm_ext;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic        load;
    logic        xfer;
    logic        out_is_cti;
    logic        cti_hist;
    logic        delay_slot;

    // unpack the queue head
    assign head_pc    = head_data[ENTRY_PC_LSB +: 32];
    assign head_instr = head_data[ENTRY_INSTR_LSB +: 32];
    assign head_err   = head_data[ENTRY_ERR_BIT];

    // instruction fields
    assign op    = opcode_e'(head_instr[31:26]);
    assign rs    = head_instr[25:21];
    assign funct = head_instr[5:0];
    assign imm   = head_instr[15:0];

    // opcode classification
    always_comb begin
        case (op)
            OPC_SPECIAL: op_class = (funct == FUNCT_JR) ? OP_JUMP : OP_ALU_R;
            OPC_J, OPC_JAL: op_class = OP_JUMP;
            OPC_REGIMM, OPC_BEQ, OPC_BNE,
            OPC_BLEZ, OPC_BGTZ: op_class = OP_BRANCH;
            OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
            OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: op_class = OP_ALU_I;
            OPC_LB, OPC_LH, OPC_LWL, OPC_LW,
            OPC_LBU, OPC_LHU: op_class = OP_LOAD;
            OPC_SB, OPC_SH, OPC_SW: op_class = OP_STORE;
            // only the eret form of cop0 is known
            OPC_COP0: begin
                if (rs == RS_CO && funct == FUNCT_ERET) begin
                    op_class = OP_ERET;
                end else begin
                    op_class = OP_RESERVED;
                end
            end
            default: op_class = OP_RESERVED;
        endcase
    end

    // logical immediates are zero extended
    assign zero_ext = (op == OPC_ANDI) || (op == OPC_ORI) || (op == OPC_XORI);
    assign imm_ext  = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // targets relative to the delay slot pc
    assign pc_plus4      = head_pc + 32'd4;
    // branch offset always sign extended
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], head_instr[25:0], 2'b00};

    // output stage handshake
    assign xfer = out_valid && out_ready;
    assign load = !empty && (!out_valid || out_ready);
    assign pop  = load;

    // branch or jump currently held in the output stage
    assign out_is_cti = (out_op_class == OP_BRANCH) || (out_op_class == OP_JUMP);

    // predecessor is either the item leaving now or the last one gone
    assign delay_slot = out_valid ? out_is_cti : cti_hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            cti_hist  <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (xfer) begin
                out_valid <= 1'b0;
            end
            if (xfer) begin
                cti_hist <= out_is_cti;
            end
        end
    end

    // payload, held while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc            <= head_pc;
            out_op_class      <= op_class;
            out_rs            <= rs;
            out_rt            <= head_instr[20:16];
            out_rd            <= head_instr[15:11];
            out_sa            <= head_instr[10:6];
            out_funct         <= funct;
            out_imm_ext       <= imm_ext;
            out_branch_target <= branch_target;
            out_jump_target   <= jump_target;
            out_in_delay_slot <= delay_slot;
            out_addr_err      <= head_err;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_frontend.sv ====
`default_nettype none

module decode_frontend #(
    parameter int IMEM_DEPTH  = 256,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             paddr,
    input  logic [31:0]             pwdata,
    input  logic                    out_ready,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    out_valid,
    output logic [31:0]             out_pc,
    output frontend_pkg::op_class_e out_op_class,
    output logic [4:0]              out_rs,
    output logic [4:0]              out_rt,
    output logic [4:0]              out_rd,
    output logic [4:0]              out_sa,
    output logic [5:0]              out_funct,
    output logic [31:0]             out_imm_ext,
    output logic [31:0]             out_branch_target,
    output logic [31:0]             out_jump_target,
    output logic                    out_in_delay_slot,
    output logic                    out_addr_err
);
    import frontend_pkg::*;

    // host memory to fetch
    logic               run;
    logic [31:0]        start_pc;
    logic [31:0]        fetch_addr;
    logic [31:0]        fetch_instr;
    // fetch to queue to decode
    logic               push;
    logic [QUEUE_W-1:0] push_data;
    logic               full;
    logic               empty;
    logic               pop;
    logic [QUEUE_W-1:0] head_data;

    imem_apb #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .fetch_addr  (fetch_addr),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .fetch_instr (fetch_instr),
        .run         (run),
        .start_pc    (start_pc)
    );

    fetch_unit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .start_pc    (start_pc),
        .fetch_instr (fetch_instr),
        .full        (full),
        .fetch_addr  (fetch_addr),
        .push        (push),
        .push_data   (push_data)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .full      (full),
        .empty     (empty)
    );

    decode_unit u_decode (
        .clk               (clk),
        .rst               (rst),
        .empty             (empty),
        .head_data         (head_data),
        .out_ready         (out_ready),
        .pop               (pop),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_op_class      (out_op_class),
        .out_rs            (out_rs),
        .out_rt            (out_rt),
        .out_rd            (out_rd),
        .out_sa            (out_sa),
        .out_funct         (out_funct),
        .out_imm_ext       (out_imm_ext),
        .out_branch_target (out_branch_target),
        .out_jump_target   (out_jump_target),
        .out_in_delay_slot (out_in_delay_slot),
        .out_addr_err      (out_addr_err)
    );

endmodule

`default_nettype wire

// ==== sim/tb_apb_tasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// two-phase write, setup then access
task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // transfer completes here, pready is tied high
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

// read, data sampled mid access phase
task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

`endif

// ==== sim/tb_decode_frontend.sv ====
`default_nettype none

module tb_decode_frontend;
    timeunit 1ns;
    timeprecision 1ps;
    import frontend_pkg::*;

    localparam int          MEM_WORDS = 32;
    localparam int          PROG_LEN  = 24;
    localparam int          QDEPTH    = 4;
    localparam logic [31:0] BAD_ADDR  = 32'h0000_0800;
    // items per run: sequential, backpressure, misaligned, aligned
    localparam int ITEM_SUM   = 32 + 48 + 16 + 16;
    localparam int APB_CYCLES = 3 * (2 * MEM_WORDS + 20) + 8;
    localparam int LIMIT      = (ITEM_SUM + 4 * 12) * 4 + APB_CYCLES + 64;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [31:0] paddr = '0;
    logic [31:0] pwdata = '0;
    logic        out_ready = 1'b0;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        out_valid;
    logic [31:0] out_pc;
    op_class_e   out_op_class;
    logic [4:0]  out_rs;
    logic [4:0]  out_rt;
    logic [4:0]  out_rd;
    logic [4:0]  out_sa;
    logic [5:0]  out_funct;
    logic [31:0] out_imm_ext;
    logic [31:0] out_branch_target;
    logic [31:0] out_jump_target;
    logic        out_in_delay_slot;
    logic        out_addr_err;

    // reference state
    logic [31:0] mem_img [MEM_WORDS];
    logic [31:0] run_pc = '0;
    int          base_cnt = 0;
    int          xfer_cnt = 0;
    int          cycles = 0;
    int          chk_err = 0;
    int          apb_err = 0;
    logic        prev_cti = 1'b0;
    logic        ready_random = 1'b0;
    logic [15:0] lfsr = 16'd83;
    string       test_name = "reset";
    int          word;
    logic [31:0] exp_instr;
    logic [31:0] exp_pc;
    logic [31:0] exp_imm;
    logic [31:0] exp_pc4;
    logic [31:0] exp_btgt;
    logic [31:0] exp_jtgt;
    op_class_e   exp_class;

    `include "tb_apb_tasks.svh"

    decode_frontend #(
        .IMEM_DEPTH  (MEM_WORDS),
        .QUEUE_DEPTH (QDEPTH)
    ) u_dut (
        .clk               (clk),
        .rst               (rst),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .out_ready         (out_ready),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_op_class      (out_op_class),
        .out_rs            (out_rs),
        .out_rt            (out_rt),
        .out_rd            (out_rd),
        .out_sa            (out_sa),
        .out_funct         (out_funct),
        .out_imm_ext       (out_imm_ext),
        .out_branch_target (out_branch_target),
        .out_jump_target   (out_jump_target),
        .out_in_delay_slot (out_in_delay_slot),
        .out_addr_err      (out_addr_err)
    );

    always #5 clk = ~clk;

    // class rules straight from the opcode map
    function automatic op_class_e ref_class(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == 6'd0) return (w[5:0] == 6'd8) ? OP_JUMP : OP_ALU_R;
        if (op == 6'd2 || op == 6'd3) return OP_JUMP;
        if (op == 6'd1 || (op >= 6'd4 && op <= 6'd7)) return OP_BRANCH;
        if (op >= 6'd8 && op <= 6'd15) return OP_ALU_I;
        if (op >= 6'd32 && op <= 6'd37) return OP_LOAD;
        if (op == 6'd40 || op == 6'd41 || op == 6'd43) return OP_STORE;
        if (op == 6'd16 && w[25:21] == 5'd16 && w[5:0] == 6'd24) return OP_ERET;
        return OP_RESERVED;
    endfunction

    // andi, ori, xori zero extend
    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        if (w[31:26] >= 6'd12 && w[31:26] <= 6'd14) return {16'h0000, w[15:0]};
        return {{16{w[15]}}, w[15:0]};
    endfunction

    // expected item for the current scoreboard index
    always_comb begin
        word      = (int'(run_pc[6:2]) + xfer_cnt - base_cnt) % MEM_WORDS;
        exp_pc    = run_pc;
        exp_pc[6:2] = 5'(word);
        exp_instr = mem_img[word];
        exp_class = ref_class(exp_instr);
        exp_imm   = ref_imm(exp_instr);
        exp_pc4   = exp_pc + 32'd4;
        // branch offset is signed for every opcode
        exp_btgt  = exp_pc4 + {{14{exp_instr[15]}}, exp_instr[15:0], 2'b00};
        exp_jtgt  = {exp_pc4[31:28], exp_instr[25:0], 2'b00};
    end

    // transfer count and delay-slot history
    always @(posedge clk) begin
        if (rst) begin
            xfer_cnt <= 0;
            prev_cti <= 1'b0;
        end else if (out_valid && out_ready) begin
            xfer_cnt <= xfer_cnt + 1;
            prev_cti <= (exp_class == OP_BRANCH) || (exp_class == OP_JUMP);
        end
    end

    // random ready, one lfsr step per bit
    always @(posedge clk) begin
        if (rst || !ready_random) begin
            out_ready <= 1'b1;
        end else begin
            lfsr      <= lfsr_next(lfsr);
            out_ready <= lfsr[0];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    a_pc: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_pc == exp_pc)
        else begin
            $display("[ERROR] %s pc exp %h got %h", test_name, exp_pc, out_pc);
            chk_err++;
        end
    a_class: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_op_class == exp_class)
        else begin
            $display("[ERROR] %s class exp %0d got %0d", test_name, exp_class, out_op_class);
            chk_err++;
        end
    a_fields: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |->
        {out_rs, out_rt, out_rd, out_sa, out_funct} == exp_instr[25:0])
        else begin
            $display("[ERROR] %s fields exp %h got %h", test_name, exp_instr[25:0],
                {out_rs, out_rt, out_rd, out_sa, out_funct});
            chk_err++;
        end
    a_imm: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_imm_ext == exp_imm)
        else begin
            $display("[ERROR] %s imm exp %h got %h", test_name, exp_imm, out_imm_ext);
            chk_err++;
        end
    a_btgt: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_branch_target == exp_btgt)
        else begin
            $display("[ERROR] %s branch target exp %h got %h", test_name,
                exp_btgt, out_branch_target);
            chk_err++;
        end
    a_jtgt: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_jump_target == exp_jtgt)
        else begin
            $display("[ERROR] %s jump target exp %h got %h", test_name,
                exp_jtgt, out_jump_target);
            chk_err++;
        end
    a_slot: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_in_delay_slot == prev_cti)
        else begin
            $display("[ERROR] %s delay slot exp %b got %b", test_name, prev_cti,
                out_in_delay_slot);
            chk_err++;
        end
    a_err: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> out_addr_err == (exp_pc[1:0] != 2'b00))
        else begin
            $display("[ERROR] %s addr_err exp %b got %b", test_name,
                exp_pc[1:0] != 2'b00, out_addr_err);
            chk_err++;
        end
    // stalled output holds
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pc)
        && $stable(out_op_class) && $stable(out_rs) && $stable(out_rt)
        && $stable(out_rd) && $stable(out_sa) && $stable(out_funct)
        && $stable(out_imm_ext) && $stable(out_branch_target)
        && $stable(out_jump_target) && $stable(out_in_delay_slot)
        && $stable(out_addr_err)))
        else begin
            $display("%s: stalled output dropped or changed", test_name);
            chk_err++;
        end
    a_slverr: assert property (@(posedge clk) disable iff (rst)
        pslverr == (psel && penable && paddr == BAD_ADDR))
        else begin
            $display("%s: pslverr wrong for address %h", test_name, paddr);
            chk_err++;
        end
    // zero wait state slave
    a_pready: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
        else begin
            $display("%s: pready low in access phase", test_name);
            chk_err++;
        end

    task automatic readback_check(input logic [31:0] addr, input logic [31:0] exp_val);
        logic [31:0] got;
        apb_read(addr, got);
        if (got !== exp_val) begin
            $display("[ERROR] %s read %h exp %h got %h", test_name, addr, exp_val, got);
            apb_err++;
        end
    endtask

    // wait for quiet output with ready held high
    task automatic drain();
        int idle;
        idle = 0;
        @(posedge clk);
        ready_random <= 1'b0;
        while (idle < 8) begin
            @(negedge clk);
            idle = out_valid ? 0 : idle + 1;
        end
    endtask

    task automatic run_from(input string name, input logic [31:0] pc, input int n,
                            input logic rnd);
        @(negedge clk);
        test_name = name;
        base_cnt  = xfer_cnt;
        run_pc    = pc;
        @(posedge clk);
        ready_random <= rnd;
        apb_write(START_PC_ADDR, pc);
        apb_write(CTRL_ADDR, 32'h1);
        while (xfer_cnt - base_cnt < n) begin
            @(negedge clk);
        end
        apb_write(CTRL_ADDR, 32'h0);
        drain();
        $display("test %s done, %0d items", name, xfer_cnt - base_cnt);
    endtask

    initial begin
        logic [31:0] dummy;
        mem_img = '{32'h00851021, 32'h00042080, 32'h2084FFFC, 32'h10A0FFFD,
                    32'h00000000, 32'h3086800F, 32'h34E7F00D, 32'h38A5FFFF,
                    32'h3C0A8000, 32'h08000010, 32'h8D2B0004, 32'h0C000003,
                    32'h03E00008, 32'hAD2BFFF8, 32'h14A20005, 32'h80AC0001,
                    32'h42000018, 32'hFC000000, 32'h1880FFFE, 32'h1CA00003,
                    32'h0481FFFF, 32'hA5CD0002, 32'h2908FFFF, 32'h94AE8000,
                    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
        // fill above the program, every address bit shows up
        for (int i = PROG_LEN; i < MEM_WORDS; i++) begin
            mem_img[i] = 32'h2400_0000 | (32'(i) << 16) | (32'(i) * 32'd4);
        end
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_name = "apb";
        for (int i = 0; i < MEM_WORDS; i++) begin
            apb_write(32'(i * 4), mem_img[i]);
        end
        apb_write(START_PC_ADDR, 32'h0000_0040);
        for (int i = 0; i < MEM_WORDS; i++) begin
            readback_check(32'(i * 4), mem_img[i]);
        end
        readback_check(START_PC_ADDR, 32'h0000_0040);
        apb_write(BAD_ADDR, 32'hDEAD_BEEF);
        apb_read(BAD_ADDR, dummy);
        $display("test apb done, %0d read errors", apb_err);

        run_from("sequential", 32'h0000_0000, 32, 1'b0);
        run_from("backpressure", 32'h0000_0040, 48, 1'b1);
        run_from("addr_err", 32'h0000_0102, 16, 1'b1);
        run_from("aligned", 32'h0000_0008, 16, 1'b1);

        $display("tests 5, transfers %0d, errors %0d", xfer_cnt, chk_err + apb_err);
        if (chk_err + apb_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+sim
design/frontend_pkg.sv
design/imem_apb.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/decode_unit.sv
design/decode_frontend.sv
sim/tb_decode_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_decode_frontend -f filelist.f -o sim_tb

out="$(./obj_dir/sim_tb)"
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
